/* src/scb_config.svh */
`ifndef SCB_CONFIG_SVH
`define SCB_CONFIG_SVH

// sid index bits, the wrap bit sits on top
`define SCB_SID_WIDTH 3

// architectural register index
`define SCB_REG_WIDTH 5

// alu0, alu1, beu, lsu
`define SCB_NUM_UNITS 4

`endif

/* src/scb_pkg.sv */
`include "scb_config.svh"

package scb_pkg;

    typedef struct packed {
        logic                      wrap;
        logic [`SCB_SID_WIDTH-1:0] idx;
    } sid_t;

    typedef logic [`SCB_REG_WIDTH-1:0] reg_idx_t;

    // bit positions of the one-hot unit grant
    typedef enum logic [1:0] {
        UNIT_ALU0 = 2'd0,
        UNIT_ALU1 = 2'd1,
        UNIT_BEU  = 2'd2,
        UNIT_LSU  = 2'd3
    } unit_e;

    typedef enum logic [1:0] {
        CLASS_ALU = 2'd0,
        CLASS_BEU = 2'd1,
        CLASS_LSU = 2'd2
    } exe_class_e;

    typedef struct packed {
        logic       vld;
        exe_class_e exe_class;
        reg_idx_t   rd;
        reg_idx_t   rs1;
        reg_idx_t   rs2;
    } dec_slot_t;

    typedef struct packed {
        logic     vld;
        sid_t     sid;
        reg_idx_t rd;
        reg_idx_t rs1;
        reg_idx_t rs2;
    } op_slot_t;

    typedef struct packed {
        logic     vld;
        sid_t     sid;
        reg_idx_t rd;
    } wb_slot_t;

    typedef struct packed {
        logic vld;
        sid_t sid;
    } redirect_t;

    typedef struct packed {
        logic     busy;
        reg_idx_t rd;
        reg_idx_t rs1;
        reg_idx_t rs2;
        sid_t     sid;
    } entry_t;

    // a younger than b, index order flips across a wrap
    function automatic logic sid_newer(input sid_t a, input sid_t b);
        return (a.wrap == b.wrap) ? (a.idx > b.idx) : (a.idx < b.idx);
    endfunction

endpackage

/* src/scb_issue_arbiter.sv */
`include "scb_config.svh"

module scb_issue_arbiter (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  scb_pkg::dec_slot_t [1:0]              dec_i,
    input  scb_pkg::entry_t [`SCB_NUM_UNITS-1:0]  entries_i,
    input  logic [1:0]                            op_stall_i,
    input  scb_pkg::redirect_t                    redirect_i,
    output logic [1:0]                            dec_stall_o,
    output logic [1:0]                            dec_flush_o,
    output scb_pkg::sid_t [1:0]                   dec_sid_o,
    output logic [1:0][`SCB_NUM_UNITS-1:0]        unit_grant_o,
    output logic [`SCB_NUM_UNITS-1:0]             wr_en_o,
    output logic [`SCB_NUM_UNITS-1:0]             wr_slot_o,
    output scb_pkg::sid_t [`SCB_NUM_UNITS-1:0]    wr_sid_o
);

    localparam int NU = `SCB_NUM_UNITS;
    localparam int SW = `SCB_SID_WIDTH + 1;

    logic [NU-1:0]  busy;
    logic [1:0]     waw;
    logic           pair_waw;
    logic [1:0]     acc;
    logic [SW-1:0]  sid_inc;
    scb_pkg::sid_t  sid_cnt;

    // occ holds units that are busy or already taken this cycle
    function automatic logic [NU-1:0] pick_unit(
        input scb_pkg::dec_slot_t d,
        input logic [NU-1:0]      occ
    );
        logic [NU-1:0] g;
        g = '0;
        if (d.vld) begin
            case (d.exe_class)
                scb_pkg::CLASS_ALU: begin
                    if (!occ[scb_pkg::UNIT_ALU0]) begin
                        g[scb_pkg::UNIT_ALU0] = 1'b1;
                    end else if (!occ[scb_pkg::UNIT_ALU1]) begin
                        g[scb_pkg::UNIT_ALU1] = 1'b1;
                    end
                end
                scb_pkg::CLASS_BEU: g[scb_pkg::UNIT_BEU] = !occ[scb_pkg::UNIT_BEU];
                scb_pkg::CLASS_LSU: g[scb_pkg::UNIT_LSU] = !occ[scb_pkg::UNIT_LSU];
                default: g = '0;
            endcase
        end
        return g;
    endfunction

    always_comb begin
        for (int u = 0; u < NU; u++) begin
            busy[u] = entries_i[u].busy;
        end
        for (int s = 0; s < 2; s++) begin
            waw[s] = 1'b0;
            for (int u = 0; u < NU; u++) begin
                if (entries_i[u].busy && entries_i[u].rd == dec_i[s].rd) begin
                    waw[s] = 1'b1;
                end
            end
        end
    end

    // slot 0 picks first, slot 1 sees its choice as occupied
    assign unit_grant_o[0] = waw[0] ? '0 : pick_unit(dec_i[0], busy);
    assign unit_grant_o[1] = waw[1] ? '0 : pick_unit(dec_i[1], busy | unit_grant_o[0]);

    assign pair_waw = dec_i[0].vld && dec_i[1].vld && (dec_i[0].rd == dec_i[1].rd);

    assign dec_stall_o[0] = dec_i[0].vld && (unit_grant_o[0] == '0 || op_stall_i[0]);
    assign dec_stall_o[1] = dec_i[1].vld && (unit_grant_o[1] == '0 || pair_waw ||
                                             op_stall_i[1] || dec_stall_o[0]);

    assign acc[0] = dec_i[0].vld && !dec_stall_o[0];
    assign acc[1] = dec_i[1].vld && !dec_stall_o[1];

    assign dec_sid_o[0] = sid_cnt;
    assign dec_sid_o[1] = acc[0] ? scb_pkg::sid_t'(sid_cnt + SW'(1)) : sid_cnt;

    assign sid_inc = SW'(acc[0]) + SW'(acc[1]);

    always_comb begin
        for (int s = 0; s < 2; s++) begin
            dec_flush_o[s] = redirect_i.vld && scb_pkg::sid_newer(dec_sid_o[s], redirect_i.sid);
        end
    end

    // grants never overlap, so at most one slot writes a unit
    always_comb begin
        for (int u = 0; u < NU; u++) begin
            wr_slot_o[u] = unit_grant_o[1][u] && acc[1];
            wr_en_o[u]   = (unit_grant_o[0][u] && acc[0]) || wr_slot_o[u];
            wr_sid_o[u]  = wr_slot_o[u] ? dec_sid_o[1] : dec_sid_o[0];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sid_cnt <= '0;
        end else begin
            sid_cnt <= scb_pkg::sid_t'(sid_cnt + sid_inc);
        end
    end

endmodule

/* src/scb_entry.sv */
module scb_entry (
    input  logic                     clk,
    input  logic                     rst_n,
    input  scb_pkg::dec_slot_t [1:0] dec_i,
    input  logic                     wr_en_i,
    input  logic                     wr_slot_i,
    input  scb_pkg::sid_t            wr_sid_i,
    input  logic [1:0]               rel_i,
    input  scb_pkg::sid_t [1:0]      rel_sid_i,
    input  scb_pkg::redirect_t       redirect_i,
    output scb_pkg::entry_t          entry_o
);

    logic              busy_q;
    scb_pkg::sid_t     sid_q;
    scb_pkg::reg_idx_t rd_q;
    scb_pkg::reg_idx_t rs1_q;
    scb_pkg::reg_idx_t rs2_q;
    logic              flush;
    logic              rel_hit;

    assign flush = redirect_i.vld && scb_pkg::sid_newer(sid_q, redirect_i.sid);

    assign rel_hit = (rel_i[0] && rel_sid_i[0] == sid_q) ||
                     (rel_i[1] && rel_sid_i[1] == sid_q);

    // flush beats write, write beats release
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_q <= 1'b0;
            sid_q  <= '0;
        end else if (flush) begin
            busy_q <= 1'b0;
        end else if (wr_en_i) begin
            busy_q <= 1'b1;
            sid_q  <= wr_sid_i;
        end else if (rel_hit) begin
            busy_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en_i && !flush) begin
            rd_q  <= dec_i[wr_slot_i].rd;
            rs1_q <= dec_i[wr_slot_i].rs1;
            rs2_q <= dec_i[wr_slot_i].rs2;
        end
    end

    assign entry_o.busy = busy_q;
    assign entry_o.rd   = rd_q;
    assign entry_o.rs1  = rs1_q;
    assign entry_o.rs2  = rs2_q;
    assign entry_o.sid  = sid_q;

endmodule

/* src/scb_raw_check.sv */
`include "scb_config.svh"

module scb_raw_check (
    input  scb_pkg::op_slot_t [1:0]              op_i,
    input  scb_pkg::entry_t [`SCB_NUM_UNITS-1:0] entries_i,
    input  scb_pkg::redirect_t                   redirect_i,
    output logic [1:0]                           op_stall_o,
    output logic [1:0]                           op_flush_o
);

    localparam int NU = `SCB_NUM_UNITS;

    logic [1:0] raw_entry;
    logic [1:0] raw_pair;

    // older busy entries writing one of the sources
    always_comb begin
        for (int s = 0; s < 2; s++) begin
            raw_entry[s] = 1'b0;
            for (int u = 0; u < NU; u++) begin
                if (entries_i[u].busy &&
                    scb_pkg::sid_newer(op_i[s].sid, entries_i[u].sid) &&
                    (entries_i[u].rd == op_i[s].rs1 || entries_i[u].rd == op_i[s].rs2)) begin
                    raw_entry[s] = 1'b1;
                end
            end
        end
    end

    // the other operand slot, only when it is the older one
    always_comb begin
        for (int s = 0; s < 2; s++) begin
            raw_pair[s] = op_i[1-s].vld &&
                          scb_pkg::sid_newer(op_i[s].sid, op_i[1-s].sid) &&
                          (op_i[1-s].rd == op_i[s].rs1 || op_i[1-s].rd == op_i[s].rs2);
        end
    end

    always_comb begin
        for (int s = 0; s < 2; s++) begin
            op_stall_o[s] = op_i[s].vld && (raw_entry[s] || raw_pair[s]);
            op_flush_o[s] = redirect_i.vld && scb_pkg::sid_newer(op_i[s].sid, redirect_i.sid);
        end
    end

endmodule

/* src/scb_wb_ctrl.sv */
module scb_wb_ctrl (
    input  scb_pkg::wb_slot_t [1:0] wb_i,
    input  scb_pkg::redirect_t      redirect_i,
    output logic [1:0]              wb_stall_o,
    output logic [1:0]              wb_flush_o,
    output logic [1:0]              rel_o,
    output scb_pkg::sid_t [1:0]     rel_sid_o
);

    logic same_rd;

    // two writebacks to one register, the older goes first
    assign same_rd = wb_i[0].vld && wb_i[1].vld && (wb_i[0].rd == wb_i[1].rd);

    assign wb_stall_o[0] = same_rd && scb_pkg::sid_newer(wb_i[0].sid, wb_i[1].sid);
    assign wb_stall_o[1] = same_rd && scb_pkg::sid_newer(wb_i[1].sid, wb_i[0].sid);

    always_comb begin
        for (int s = 0; s < 2; s++) begin
            rel_o[s]      = wb_i[s].vld && !wb_stall_o[s];
            rel_sid_o[s]  = wb_i[s].sid;
            wb_flush_o[s] = redirect_i.vld && scb_pkg::sid_newer(wb_i[s].sid, redirect_i.sid);
        end
    end

endmodule

/* src/scoreboard.sv */
`include "scb_config.svh"

module scoreboard (
    input  logic                           clk,
    input  logic                           rst_n,
    // decoder
    input  scb_pkg::dec_slot_t [1:0]       dec_i,
    output logic [1:0]                     dec_stall_o,
    output logic [1:0]                     dec_flush_o,
    output scb_pkg::sid_t [1:0]            dec_sid_o,
    output logic [1:0][`SCB_NUM_UNITS-1:0] unit_grant_o,
    // operand stage
    input  scb_pkg::op_slot_t [1:0]        op_i,
    output logic [1:0]                     op_stall_o,
    output logic [1:0]                     op_flush_o,
    // writeback
    input  scb_pkg::wb_slot_t [1:0]        wb_i,
    output logic [1:0]                     wb_stall_o,
    output logic [1:0]                     wb_flush_o,
    input  scb_pkg::redirect_t             redirect_i
);

    scb_pkg::entry_t [`SCB_NUM_UNITS-1:0] entries;
    logic [`SCB_NUM_UNITS-1:0]            wr_en;
    logic [`SCB_NUM_UNITS-1:0]            wr_slot;
    scb_pkg::sid_t [`SCB_NUM_UNITS-1:0]   wr_sid;
    logic [1:0]                           rel;
    scb_pkg::sid_t [1:0]                  rel_sid;

    scb_issue_arbiter u_arbiter (
        .clk          (clk),
        .rst_n        (rst_n),
        .dec_i        (dec_i),
        .entries_i    (entries),
        .op_stall_i   (op_stall_o),
        .redirect_i   (redirect_i),
        .dec_stall_o  (dec_stall_o),
        .dec_flush_o  (dec_flush_o),
        .dec_sid_o    (dec_sid_o),
        .unit_grant_o (unit_grant_o),
        .wr_en_o      (wr_en),
        .wr_slot_o    (wr_slot),
        .wr_sid_o     (wr_sid)
    );

    // one entry per unit_e position
    for (genvar u = 0; u < `SCB_NUM_UNITS; u++) begin : g_entry
        scb_entry u_entry (
            .clk        (clk),
            .rst_n      (rst_n),
            .dec_i      (dec_i),
            .wr_en_i    (wr_en[u]),
            .wr_slot_i  (wr_slot[u]),
            .wr_sid_i   (wr_sid[u]),
            .rel_i      (rel),
            .rel_sid_i  (rel_sid),
            .redirect_i (redirect_i),
            .entry_o    (entries[u])
        );
    end

    scb_raw_check u_raw_check (
        .op_i       (op_i),
        .entries_i  (entries),
        .redirect_i (redirect_i),
        .op_stall_o (op_stall_o),
        .op_flush_o (op_flush_o)
    );

    scb_wb_ctrl u_wb_ctrl (
        .wb_i       (wb_i),
        .redirect_i (redirect_i),
        .wb_stall_o (wb_stall_o),
        .wb_flush_o (wb_flush_o),
        .rel_o      (rel),
        .rel_sid_o  (rel_sid)
    );

endmodule

/* dv/scoreboard_tb.sv */
`include "scb_config.svh"

module scoreboard_tb;

    localparam int NU              = `SCB_NUM_UNITS;
    localparam int SW              = `SCB_SID_WIDTH + 1;
    localparam int RW              = `SCB_REG_WIDTH;
    localparam int RESET_CYCLES    = 16;
    localparam int DIR_CYCLES      = 20;
    localparam int RAND_CYCLES     = 600;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + DIR_CYCLES + RAND_CYCLES + 100;

    logic clk;
    logic rst_n;
    integer seed;

    scb_pkg::dec_slot_t [1:0] dec;
    scb_pkg::op_slot_t [1:0]  op;
    scb_pkg::wb_slot_t [1:0]  wb;
    scb_pkg::redirect_t       redirect;

    logic [1:0]          dec_stall;
    logic [1:0]          dec_flush;
    scb_pkg::sid_t [1:0] dec_sid;
    logic [1:0][NU-1:0]  unit_grant;
    logic [1:0]          op_stall;
    logic [1:0]          op_flush;
    logic [1:0]          wb_stall;
    logic [1:0]          wb_flush;

    // model of the entries and the sid counter
    logic [NU-1:0]                    m_busy;
    scb_pkg::reg_idx_t [NU-1:0]       m_rd;
    logic [NU-1:0][SW-1:0]            m_sid;
    logic [SW-1:0]                    m_cnt;

    logic [1:0]          e_waw;
    logic [1:0]          e_raw;
    logic [1:0]          e_acc;
    logic [1:0]          e_rel;
    logic [1:0]          e_dec_stall;
    logic [1:0]          e_dec_flush;
    logic [1:0]          e_op_stall;
    logic [1:0]          e_op_flush;
    logic [1:0]          e_wb_stall;
    logic [1:0]          e_wb_flush;
    logic [1:0][SW-1:0]  e_sid;
    logic [1:0][NU-1:0]  e_grant;

    scoreboard uut (
        .clk          (clk),
        .rst_n        (rst_n),
        .dec_i        (dec),
        .dec_stall_o  (dec_stall),
        .dec_flush_o  (dec_flush),
        .dec_sid_o    (dec_sid),
        .unit_grant_o (unit_grant),
        .op_i         (op),
        .op_stall_o   (op_stall),
        .op_flush_o   (op_flush),
        .wb_i         (wb),
        .wb_stall_o   (wb_stall),
        .wb_flush_o   (wb_flush),
        .redirect_i   (redirect)
    );

    always #5 clk = ~clk;

    // a is younger when it lies less than half the sid space ahead of b
    function automatic logic is_younger(input logic [SW-1:0] a, input logic [SW-1:0] b);
        logic [SW-1:0] d;
        d = a - b;
        return (d != '0) && !d[SW-1];
    endfunction

    function automatic logic [NU-1:0] expected_grant(
        input scb_pkg::dec_slot_t d,
        input logic               waw,
        input logic [NU-1:0]      taken
    );
        int u;
        u = -1;
        if (d.vld && !waw) begin
            if (d.exe_class == scb_pkg::CLASS_ALU) begin
                if (!taken[scb_pkg::UNIT_ALU0]) begin
                    u = int'(scb_pkg::UNIT_ALU0);
                end else if (!taken[scb_pkg::UNIT_ALU1]) begin
                    u = int'(scb_pkg::UNIT_ALU1);
                end
            end else if (d.exe_class == scb_pkg::CLASS_BEU && !taken[scb_pkg::UNIT_BEU]) begin
                u = int'(scb_pkg::UNIT_BEU);
            end else if (d.exe_class == scb_pkg::CLASS_LSU && !taken[scb_pkg::UNIT_LSU]) begin
                u = int'(scb_pkg::UNIT_LSU);
            end
        end
        return (u < 0) ? '0 : (NU'(1) << u);
    endfunction

    always_comb begin
        for (int s = 0; s < 2; s++) begin
            e_waw[s] = 1'b0;
            e_raw[s] = 1'b0;
            for (int u = 0; u < NU; u++) begin
                if (m_busy[u] && m_rd[u] == dec[s].rd) begin
                    e_waw[s] = 1'b1;
                end
                if (m_busy[u] && is_younger(op[s].sid, m_sid[u]) &&
                    (m_rd[u] == op[s].rs1 || m_rd[u] == op[s].rs2)) begin
                    e_raw[s] = 1'b1;
                end
            end
            if (op[1-s].vld && is_younger(op[s].sid, op[1-s].sid) &&
                (op[1-s].rd == op[s].rs1 || op[1-s].rd == op[s].rs2)) begin
                e_raw[s] = 1'b1;
            end
            e_op_stall[s] = op[s].vld && e_raw[s];
        end
        e_grant[0] = expected_grant(dec[0], e_waw[0], m_busy);
        e_grant[1] = expected_grant(dec[1], e_waw[1], m_busy | e_grant[0]);
        e_dec_stall[0] = dec[0].vld && (e_grant[0] == '0 || e_op_stall[0]);
        e_dec_stall[1] = dec[1].vld && (e_grant[1] == '0 || e_op_stall[1] || e_dec_stall[0] ||
                                         (dec[0].vld && dec[0].rd == dec[1].rd));
        e_acc = {dec[1].vld && !e_dec_stall[1], dec[0].vld && !e_dec_stall[0]};
        e_sid[0] = m_cnt;
        e_sid[1] = m_cnt + SW'(e_acc[0]);
        for (int s = 0; s < 2; s++) begin
            e_dec_flush[s] = redirect.vld && is_younger(e_sid[s], redirect.sid);
            e_op_flush[s]  = redirect.vld && is_younger(op[s].sid, redirect.sid);
            e_wb_flush[s]  = redirect.vld && is_younger(wb[s].sid, redirect.sid);
            e_wb_stall[s]  = wb[0].vld && wb[1].vld && wb[0].rd == wb[1].rd &&
                             is_younger(wb[s].sid, wb[1-s].sid);
            e_rel[s]       = wb[s].vld && !e_wb_stall[s];
        end
    end

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            m_busy <= '0;
            m_rd   <= '0;
            m_sid  <= '0;
            m_cnt  <= '0;
        end else begin
            for (int u = 0; u < NU; u++) begin
                if (redirect.vld && is_younger(m_sid[u], redirect.sid)) begin
                    m_busy[u] <= 1'b0;
                end else if (e_acc[0] && e_grant[0][u]) begin
                    m_busy[u] <= 1'b1;
                    m_sid[u]  <= e_sid[0];
                    m_rd[u]   <= dec[0].rd;
                end else if (e_acc[1] && e_grant[1][u]) begin
                    m_busy[u] <= 1'b1;
                    m_sid[u]  <= e_sid[1];
                    m_rd[u]   <= dec[1].rd;
                end else if ((e_rel[0] && wb[0].sid == m_sid[u]) ||
                             (e_rel[1] && wb[1].sid == m_sid[u])) begin
                    m_busy[u] <= 1'b0;
                end
            end
            m_cnt <= m_cnt + SW'(e_acc[0]) + SW'(e_acc[1]);
        end
    end

    task automatic fail_check(input string msg);
        $display("Error at %0t: %s", $time, msg);
        $display("STATUS: FAIL");
        $fatal(1, "output mismatch");
    endtask

    assert property (@(negedge clk) disable iff (!rst_n) dec_stall === e_dec_stall)
        else fail_check($sformatf("dec_stall %b, expected %b", dec_stall, e_dec_stall));
    assert property (@(negedge clk) disable iff (!rst_n) dec_flush === e_dec_flush)
        else fail_check($sformatf("dec_flush %b, expected %b", dec_flush, e_dec_flush));
    assert property (@(negedge clk) disable iff (!rst_n) dec_sid === e_sid)
        else fail_check($sformatf("dec_sid %h, expected %h", dec_sid, e_sid));
    assert property (@(negedge clk) disable iff (!rst_n) unit_grant === e_grant)
        else fail_check($sformatf("unit_grant %b, expected %b", unit_grant, e_grant));
    assert property (@(negedge clk) disable iff (!rst_n) op_stall === e_op_stall)
        else fail_check($sformatf("op_stall %b, expected %b", op_stall, e_op_stall));
    assert property (@(negedge clk) disable iff (!rst_n) op_flush === e_op_flush)
        else fail_check($sformatf("op_flush %b, expected %b", op_flush, e_op_flush));
    assert property (@(negedge clk) disable iff (!rst_n) wb_stall === e_wb_stall)
        else fail_check($sformatf("wb_stall %b, expected %b", wb_stall, e_wb_stall));
    assert property (@(negedge clk) disable iff (!rst_n) wb_flush === e_wb_flush)
        else fail_check($sformatf("wb_flush %b, expected %b", wb_flush, e_wb_flush));

    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    task automatic clear_inputs();
        dec      = '0;
        op       = '0;
        wb       = '0;
        redirect = '0;
    endtask

    task automatic step();
        @(posedge clk);
        #1;
        clear_inputs();
    endtask

    task automatic set_dec(input int s, input scb_pkg::exe_class_e cls, input int rd,
                           input int rs1, input int rs2);
        dec[s].vld       = 1'b1;
        dec[s].exe_class = cls;
        dec[s].rd        = RW'(rd);
        dec[s].rs1       = RW'(rs1);
        dec[s].rs2       = RW'(rs2);
    endtask

    task automatic set_op(input int s, input int sid, input int rd, input int rs1, input int rs2);
        op[s].vld = 1'b1;
        op[s].sid = SW'(sid);
        op[s].rd  = RW'(rd);
        op[s].rs1 = RW'(rs1);
        op[s].rs2 = RW'(rs2);
    endtask

    task automatic set_wb(input int s, input int sid, input int rd);
        wb[s].vld = 1'b1;
        wb[s].sid = SW'(sid);
        wb[s].rd  = RW'(rd);
    endtask

    task automatic run_directed();
        // dual issue onto alu0 and alu1, then both alus busy
        set_dec(0, scb_pkg::CLASS_ALU, 1, 0, 0);
        set_dec(1, scb_pkg::CLASS_ALU, 2, 0, 0);
        step();
        set_dec(0, scb_pkg::CLASS_ALU, 3, 1, 2);
        set_dec(1, scb_pkg::CLASS_BEU, 4, 0, 0);
        step();
        // equal rd in the pair
        set_dec(0, scb_pkg::CLASS_BEU, 5, 0, 0);
        set_dec(1, scb_pkg::CLASS_LSU, 5, 0, 0);
        step();
        set_dec(0, scb_pkg::CLASS_LSU, 6, 0, 0);
        set_dec(1, scb_pkg::CLASS_LSU, 1, 0, 0);
        step();
        // older entry hit, younger entry ignored
        set_op(0, 4, 7, 1, 0);
        set_op(1, 0, 8, 2, 0);
        step();
        set_op(0, 5, 9, 0, 0);
        set_op(1, 6, 10, 9, 0);
        step();
        set_op(0, 6, 11, 12, 0);
        set_op(1, 5, 12, 0, 0);
        step();
        // release both alus, slot 0 still sees rd 1 busy
        set_wb(0, 0, 1);
        set_wb(1, 1, 2);
        set_dec(0, scb_pkg::CLASS_ALU, 1, 0, 0);
        step();
        set_dec(0, scb_pkg::CLASS_ALU, 1, 0, 0);
        set_dec(1, scb_pkg::CLASS_ALU, 14, 0, 0);
        set_op(0, 7, 13, 5, 0);
        step();
        set_dec(0, scb_pkg::CLASS_ALU, 1, 0, 0);
        step();
        // same rd writebacks, the younger waits
        set_wb(0, 3, 6);
        set_wb(1, 2, 6);
        set_dec(0, scb_pkg::CLASS_LSU, 9, 0, 0);
        step();
        set_dec(0, scb_pkg::CLASS_LSU, 6, 0, 0);
        step();
        set_wb(0, 3, 6);
        step();
        set_dec(0, scb_pkg::CLASS_LSU, 6, 0, 0);
        step();
        set_dec(0, scb_pkg::CLASS_ALU, 15, 0, 0);
        set_dec(1, scb_pkg::CLASS_BEU, 16, 0, 0);
        step();
        // redirect at sid 5 drops sids 6 and 7
        redirect.vld = 1'b1;
        redirect.sid = SW'(5);
        set_op(0, 6, 0, 0, 0);
        set_op(1, 4, 0, 0, 0);
        set_wb(0, 7, 16);
        set_wb(1, 5, 3);
        step();
        set_dec(0, scb_pkg::CLASS_ALU, 15, 0, 0);
        set_dec(1, scb_pkg::CLASS_BEU, 16, 0, 0);
        step();
    endtask

    task automatic run_random();
        int u;
        for (int c = 0; c < RAND_CYCLES; c++) begin
            for (int s = 0; s < 2; s++) begin
                dec[s].vld       = rand_below(4) != 0;
                dec[s].exe_class = scb_pkg::exe_class_e'(2'(rand_below(3)));
                dec[s].rd        = RW'(rand_below(8));
                dec[s].rs1       = RW'(rand_below(8));
                dec[s].rs2       = RW'(rand_below(8));
                op[s].vld        = rand_below(2) != 0;
                op[s].sid        = m_cnt - SW'(rand_below(6));
                op[s].rd         = RW'(rand_below(8));
                op[s].rs1        = RW'(rand_below(8));
                op[s].rs2        = RW'(rand_below(8));
                // mostly writebacks of real in-flight entries
                u = rand_below(NU);
                wb[s].vld        = rand_below(3) != 0;
                wb[s].sid        = m_busy[u] ? m_sid[u] : m_cnt - SW'(rand_below(8));
                wb[s].rd         = m_busy[u] ? m_rd[u] : RW'(rand_below(8));
            end
            redirect.vld = rand_below(24) == 0;
            redirect.sid = m_cnt - SW'(rand_below(8));
            step();
        end
    endtask

    initial begin
        seed    = 32'h46e6;
        clk     = 1'b0;
        rst_n   = 1'b0;
        clear_inputs();
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;
        run_directed();
        run_random();
        // let the checks of the last falling edge settle
        @(negedge clk);
        #1;
        $display("STATUS: PASS");
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * 10);
        $display("watchdog expired before the test sequence completed");
        $display("STATUS: FAIL");
        $fatal(1, "timeout");
    end

endmodule

/* scoreboard.f */
+incdir+src
src/scb_pkg.sv
src/scb_issue_arbiter.sv
src/scb_entry.sv
src/scb_raw_check.sv
src/scb_wb_ctrl.sv
src/scoreboard.sv
dv/scoreboard_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f scoreboard.f --top-module scoreboard_tb -o scoreboard_sim

# the simulator exits nonzero on $fatal, the log decides the result
./obj_dir/scoreboard_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "STATUS: FAIL" sim.log; then
    exit 1
fi
exit 0
